//--- design/wm_addr_channel.sv
/*
 * Write address channel
 * An address is issued only for a burst whose first beat has been presented
 * Addresses step by a full burst, the start address is used as given
 */
`default_nettype none

module wm_addr_channel (
  input  wire logic              aclk,
  input  wire logic              areset,
  input  wire wm_cfg_pkg::plan_t plan,
  input  wire logic              go,
  input  wire logic              burst_seen,
  input  wire logic              aw_stall,
  output logic                   awvalid,
  input  wire logic              awready,
  output wm_axi_pkg::aw_t        aw,
  output logic                   aw_accepted
);

  logic                          awvalid_r;
  logic                          awxfer;
  logic                          none_seen;
  logic                          aw_final;
  logic [wm_axi_pkg::addr_w-1:0] addr_r;

  //////////////////////////////////////////////////
  // Write address channel
  //////////////////////////////////////////////////
  assign awxfer = awvalid_r & awready;

  // Raise only with a seen burst pending and room for another response
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!awvalid_r && !none_seen && !aw_stall) begin
      awvalid_r <= 1'b1;
    end else if (awready) begin
      awvalid_r <= 1'b0;
    end
  end

  // Start address on go, then one full burst per transfer
  always_ff @(posedge aclk) begin
    if (go) begin
      addr_r <= plan.addr;
    end else if (awxfer) begin
      addr_r <= addr_r + wm_axi_pkg::addr_w'(wm_axi_pkg::burst_bytes);
    end
  end

  always_comb begin
    aw.addr = addr_r;
    // Short length for the last burst, full length otherwise
    aw.len  = (aw_final || (plan.num_trans == '0)) ? plan.final_len : 8'hff;
  end

  assign awvalid     = awvalid_r;
  assign aw_accepted = awxfer;

  // Bursts seen on W but not yet addressed, one spare bit for a full command
  wm_counter #(
    .width      (wm_cfg_pkg::trans_cntr_w + 1),
    .init_value ('0)
  ) u_seen_cntr (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_seen),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (none_seen)
  );

  // Bursts still to be addressed after the current one
  wm_counter #(
    .width      (wm_cfg_pkg::trans_cntr_w),
    .init_value ('0)
  ) u_left_cntr (
    .aclk       (aclk),
    .areset     (areset),
    .load       (go),
    .incr       (1'b0),
    .decr       (awxfer),
    .load_value (plan.num_trans),
    .count      (),
    .is_zero    (aw_final)
  );

endmodule

`default_nettype wire

//--- design/wm_axi_pkg.sv
/*
 * AXI4 write channel constants and payload structs
 * Only the AW and W fields driven by this master are carried
 * Bursts are INCR with full-width beats, so size and burst type are implied
 */
`default_nettype none

package wm_axi_pkg;

  // Bus widths
  localparam int unsigned addr_w     = 32;
  localparam int unsigned data_w     = 32;
  localparam int unsigned strb_w     = data_w / 8;
  localparam int unsigned log_strb_w = $clog2(strb_w);

  // Burst limit is the smaller of 4 KiB in beats and the AXI4 maximum of 256
  localparam int unsigned max_burst_beats = (4096 / strb_w < 256) ? 4096 / strb_w : 256;
  localparam int unsigned log_burst_beats = $clog2(max_burst_beats);
  // Address step between full bursts
  localparam int unsigned burst_bytes     = max_burst_beats * strb_w;

  // AW payload
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [7:0]        len;  // beats minus one
  } aw_t;

  // W payload
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } w_t;

endpackage

`default_nettype wire

//--- design/wm_cfg_pkg.sv
/*
 * Write master sizing, command and burst plan types
 * Command length is limited to 2^20 - 1 bytes and must not be zero
 */
`default_nettype none

package wm_cfg_pkg;

  // Command length in bytes
  localparam int unsigned xfer_size_w  = 20;
  // Total beats minus one
  localparam int unsigned total_len_w  = xfer_size_w - wm_axi_pkg::log_strb_w;
  // Bursts per command minus one
  localparam int unsigned trans_cntr_w = total_len_w - wm_axi_pkg::log_burst_beats;

  // Bursts allowed to await a write response
  localparam int unsigned max_outstanding    = 8;
  localparam int unsigned outstanding_cntr_w = $clog2(max_outstanding + 1);

  // Command as sampled on start
  typedef struct packed {
    logic [wm_axi_pkg::addr_w-1:0] addr;
    logic [xfer_size_w-1:0]        size_bytes;
  } cmd_t;

  // Burst plan shared by all three channels
  typedef struct packed {
    logic [wm_axi_pkg::addr_w-1:0]          addr;
    logic [trans_cntr_w-1:0]                num_trans;   // bursts minus one
    logic [wm_axi_pkg::log_burst_beats-1:0] final_len;   // AXI len of last burst
    logic [wm_axi_pkg::strb_w-1:0]          final_strb;  // strobe of last beat
  } plan_t;

  // Write data channel state
  typedef enum logic {WR_IDLE, WR_RUN} wr_state_t;

endpackage

`default_nettype wire

//--- design/wm_cmd_ctrl.sv
/*
 * Command capture and burst planning
 * Plan settles two cycles after start and is held until the next command
 * Size zero is not supported, start must not come while a command runs
 */
`default_nettype none

module wm_cmd_ctrl (
  input  wire logic              aclk,
  input  wire logic              areset,
  input  wire logic              start,
  input  wire wm_cfg_pkg::cmd_t  cmd,
  output wm_cfg_pkg::plan_t      plan,
  output logic                   go
);

  logic                                start_d1;
  logic                                go_r;
  logic [wm_axi_pkg::addr_w-1:0]       addr_r;
  logic [wm_cfg_pkg::total_len_w-1:0]  total_len_r;
  logic [wm_axi_pkg::log_strb_w-1:0]   rem_r;
  wm_cfg_pkg::plan_t                   plan_r;

  //////////////////////////////////////////////////
  // Command capture
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= cmd.addr;
      // Byte remainder of the last word
      rem_r  <= cmd.size_bytes[0 +: wm_axi_pkg::log_strb_w];
      // Beats minus one, a partial word counts as a full beat
      if (cmd.size_bytes[0 +: wm_axi_pkg::log_strb_w] == '0) begin
        total_len_r <= cmd.size_bytes[wm_axi_pkg::log_strb_w +: wm_cfg_pkg::total_len_w] - 1'b1;
      end else begin
        total_len_r <= cmd.size_bytes[wm_axi_pkg::log_strb_w +: wm_cfg_pkg::total_len_w];
      end
    end
  end

  //////////////////////////////////////////////////
  // Burst plan
  //////////////////////////////////////////////////
  // Upper bits count full bursts, lower bits give the last burst length
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      plan_r.addr      <= addr_r;
      plan_r.num_trans <= total_len_r[wm_axi_pkg::log_burst_beats +: wm_cfg_pkg::trans_cntr_w];
      plan_r.final_len <= total_len_r[0 +: wm_axi_pkg::log_burst_beats];
      // Bytes above the remainder are cleared, whole word when no remainder
      for (int i = 0; i < wm_axi_pkg::strb_w; i++) begin
        plan_r.final_strb[i] <= (rem_r == '0) || (i < rem_r);
      end
    end
  end

  // Start delayed two cycles, lines up with the plan register
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      go_r     <= 1'b0;
    end else begin
      start_d1 <= start;
      go_r     <= start_d1;
    end
  end

  assign plan = plan_r;
  assign go   = go_r;

endmodule

`default_nettype wire

//--- design/wm_counter.sv
/*
 * Loadable up/down counter with zero flag
 * Load wins over count, incr and decr together hold the value
 * Wraps silently in both directions
 */
`default_nettype none

module wm_counter #(
  parameter int unsigned      width      = 8,
  parameter logic [width-1:0] init_value = '0
) (
  input  wire logic             aclk,
  input  wire logic             areset,
  input  wire logic             load,
  input  wire logic             incr,
  input  wire logic             decr,
  input  wire logic [width-1:0] load_value,
  output logic      [width-1:0] count,
  output logic                  is_zero
);

  logic [width-1:0] count_r;

  always_ff @(posedge aclk) begin
    if (areset) begin
      count_r <= init_value;
    end else if (load) begin
      count_r <= load_value;
    end else if (incr && !decr) begin
      count_r <= count_r + 1'b1;
    end else if (decr && !incr) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign count   = count_r;
  assign is_zero = (count_r == '0);

endmodule

`default_nettype wire

//--- design/wm_data_channel.sv
/*
 * Write data channel, stream straight onto W with no buffering
 * Stream ready follows wready only while a command runs
 * burst_seen pulses once per burst when its first beat is presented
 */
`default_nettype none

module wm_data_channel (
  input  wire logic                          aclk,
  input  wire logic                          areset,
  input  wire wm_cfg_pkg::plan_t             plan,
  input  wire logic                          go,
  input  wire logic                          axis_tvalid,
  output logic                               axis_tready,
  input  wire logic [wm_axi_pkg::data_w-1:0] axis_tdata,
  output logic                               wvalid,
  input  wire logic                          wready,
  output wm_axi_pkg::w_t                     w,
  output logic                               burst_seen
);

  wm_cfg_pkg::wr_state_t               state;
  logic                                running;
  logic                                wxfer;
  logic                                beat_last;
  logic                                final_burst;
  logic                                almost_final;
  logic                                final_xfer;
  logic                                load_beats;
  logic                                load_final;
  logic                                first_beat;
  logic                                first_shown;
  logic                                burst_seen_r;
  logic [wm_cfg_pkg::trans_cntr_w-1:0] bursts_left;

  //////////////////////////////////////////////////
  // Write data channel
  //////////////////////////////////////////////////
  // Run from the cycle after go to the last beat of the last burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= wm_cfg_pkg::WR_IDLE;
    end else if (go) begin
      state <= wm_cfg_pkg::WR_RUN;
    end else if (final_xfer) begin
      state <= wm_cfg_pkg::WR_IDLE;
    end
  end

  assign running     = (state == wm_cfg_pkg::WR_RUN);
  assign axis_tready = wready & running;
  assign wvalid      = axis_tvalid & running;
  assign wxfer       = wvalid & wready;
  assign final_xfer  = wxfer & beat_last & final_burst;

  always_comb begin
    w.data = axis_tdata;
    w.last = beat_last;
    // Partial strobe only on the closing beat of the command
    w.strb = (beat_last && final_burst) ? plan.final_strb : '1;
  end

  // Short burst is loaded when the last burst begins
  assign almost_final = (bursts_left == wm_cfg_pkg::trans_cntr_w'(1));
  assign load_final   = (go & (plan.num_trans == '0)) | (wxfer & beat_last & almost_final);
  assign load_beats   = go | (wxfer & beat_last);

  // Beats left in this burst, zero marks last
  wm_counter #(
    .width      (wm_axi_pkg::log_burst_beats),
    .init_value ('1)
  ) u_beat_cntr (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (load_final ? plan.final_len : '1),
    .count      (),
    .is_zero    (beat_last)
  );

  // Bursts left after this one
  wm_counter #(
    .width      (wm_cfg_pkg::trans_cntr_w),
    .init_value ('0)
  ) u_burst_cntr (
    .aclk       (aclk),
    .areset     (areset),
    .load       (go),
    .incr       (1'b0),
    .decr       (wxfer & beat_last),
    .load_value (plan.num_trans),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  //////////////////////////////////////////////////
  // First beat tracking for the address channel
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      first_beat   <= 1'b1;
      first_shown  <= 1'b0;
      burst_seen_r <= 1'b0;
    end else begin
      // Next beat opens a burst once a last beat has gone
      if (wxfer) begin
        first_beat <= beat_last;
      end
      // Remember a first beat already reported while it waits for wready
      if (wxfer) begin
        first_shown <= 1'b0;
      end else if (wvalid && first_beat) begin
        first_shown <= 1'b1;
      end
      burst_seen_r <= wvalid & first_beat & ~first_shown;
    end
  end

  assign burst_seen = burst_seen_r;

endmodule

`default_nettype wire

//--- design/wm_resp_tracker.sv
/*
 * Write response tracking
 * bready is tied high at the top, so every bvalid is a transfer
 */
`default_nettype none

module wm_resp_tracker (
  input  wire logic              aclk,
  input  wire logic              areset,
  input  wire wm_cfg_pkg::plan_t plan,
  input  wire logic              go,
  input  wire logic              aw_accepted,
  input  wire logic              bvalid,
  output logic                   aw_stall,
  output logic                   done
);

  logic resp_last;
  logic done_r;

  //////////////////////////////////////////////////
  // Write response channel
  //////////////////////////////////////////////////
  // Free response slots, an address takes one and a response returns it
  wm_counter #(
    .width      (wm_cfg_pkg::outstanding_cntr_w),
    .init_value (wm_cfg_pkg::outstanding_cntr_w'(wm_cfg_pkg::max_outstanding))
  ) u_vacancy_cntr (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bvalid),
    .decr       (aw_accepted),
    .load_value ('0),
    .count      (),
    .is_zero    (aw_stall)
  );

  // Responses still due after the next one
  wm_counter #(
    .width      (wm_cfg_pkg::trans_cntr_w),
    .init_value ('0)
  ) u_resp_cntr (
    .aclk       (aclk),
    .areset     (areset),
    .load       (go),
    .incr       (1'b0),
    .decr       (bvalid),
    .load_value (plan.num_trans),
    .count      (),
    .is_zero    (resp_last)
  );

  // One pulse after the response of the last burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      done_r <= 1'b0;
    end else begin
      done_r <= bvalid & resp_last;
    end
  end

  assign done = done_r;

endmodule

`default_nettype wire

//--- design/wm_top.sv
/*
 * AXI4 write master top level
 * Stream beats become incrementing write bursts of up to 256 beats
 * First W beat is possible 3 cycles after start, done follows the last response
 */
`default_nettype none

module wm_top (
  input  wire logic                          aclk,
  input  wire logic                          areset,
  // Command
  input  wire logic                          start,
  input  wire wm_cfg_pkg::cmd_t              cmd,
  output logic                               done,
  // Stream source
  input  wire logic                          axis_tvalid,
  output logic                               axis_tready,
  input  wire logic [wm_axi_pkg::data_w-1:0] axis_tdata,
  // AXI4 write address
  output logic                               awvalid,
  input  wire logic                          awready,
  output wm_axi_pkg::aw_t                    aw,
  // AXI4 write data
  output logic                               wvalid,
  input  wire logic                          wready,
  output wm_axi_pkg::w_t                     w,
  // AXI4 write response
  input  wire logic                          bvalid,
  output logic                               bready
);

  wm_cfg_pkg::plan_t plan;
  logic              go;
  logic              burst_seen;
  logic              aw_accepted;
  logic              aw_stall;

  // Responses are always taken
  assign bready = 1'b1;

  wm_cmd_ctrl u_cmd_ctrl (
    .aclk (aclk), .areset (areset), .start (start), .cmd (cmd), .plan (plan), .go (go)
  );

  wm_data_channel u_data_channel (
    .aclk (aclk), .areset (areset), .plan (plan), .go (go),
    .axis_tvalid (axis_tvalid), .axis_tready (axis_tready), .axis_tdata (axis_tdata),
    .wvalid (wvalid), .wready (wready), .w (w), .burst_seen (burst_seen)
  );

  wm_addr_channel u_addr_channel (
    .aclk (aclk), .areset (areset), .plan (plan), .go (go),
    .burst_seen (burst_seen), .aw_stall (aw_stall),
    .awvalid (awvalid), .awready (awready), .aw (aw), .aw_accepted (aw_accepted)
  );

  wm_resp_tracker u_resp_tracker (
    .aclk (aclk), .areset (areset), .plan (plan), .go (go),
    .aw_accepted (aw_accepted), .bvalid (bvalid), .aw_stall (aw_stall), .done (done)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the write master testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_top \
  -Mdir obj_dir -o tb_top_sim \
  && ./obj_dir/tb_top_sim | tee "$log" \
  || { echo "build or run failed"; exit 1; }

grep -q "^NO ERRORS$" "$log" && echo "simulation passed" \
  || { echo "simulation failed, see $log"; exit 1; }

//--- sim/tb_top.sv
/*
 * Write master testbench with a random-ready AXI4 slave and a counting stream
 * Commands run one at a time and the next starts the cycle after done
 * The last command holds each response a few thousand cycles to fill the limit
 */
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          n_tests    = 11;
  localparam logic [31:0] word_base  = 32'h5a00_0000;
  // Added response delay for the outstanding limit command
  localparam int unsigned slow_extra = 3000;

  logic                          aclk;
  logic                          areset;
  logic                          start;
  wm_cfg_pkg::cmd_t              cmd;
  logic                          done;
  logic                          axis_tvalid = 1'b0;
  logic                          axis_tready;
  logic [wm_axi_pkg::data_w-1:0] axis_tdata  = word_base;
  logic                          awvalid;
  logic                          awready     = 1'b0;
  wm_axi_pkg::aw_t               aw;
  logic                          wvalid;
  logic                          wready      = 1'b0;
  wm_axi_pkg::w_t                w;
  logic                          bvalid      = 1'b0;
  logic                          bready;
  int unsigned                   error_count;
  int unsigned                   tests_run;
  int unsigned                   tests_passed;

  integer      seed = 32'hd1a3c501;
  logic        slow_resp;
  // Slave bookkeeping
  int unsigned aw_done;
  int unsigned wlast_done;
  int unsigned paired;
  longint      cycle;
  longint      resp_due [$];

  // Burst split, then strobe sizes, then a 10-burst command
  logic [31:0] test_addr [n_tests] = '{32'h0000_1000, 32'h0000_2000, 32'h0001_0000,
                                       32'h0002_0400, 32'h0003_0000, 32'h0004_0000,
                                       32'h0005_0000, 32'h0005_1000, 32'h0005_2000,
                                       32'h0005_3000, 32'h0010_0000};
  int unsigned test_size [n_tests] = '{4, 6, 1024, 1025, 3000, 4096, 5, 6, 7, 8, 10240};

  wm_top i_dut (.*);

  wm_checker #(.word_base(word_base)) i_check (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  //////////////////////////////////////////////////
  // AXI4 slave and stream source
  //////////////////////////////////////////////////
  always @(posedge aclk) begin : slave_model
    int unsigned delay;
    if (areset) begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      axis_tvalid <= 1'b0;
      aw_done     = 0;
      wlast_done  = 0;
      paired      = 0;
      cycle       = 0;
      resp_due.delete();
    end else begin
      awready <= ($random(seed) & 1) != 0;
      wready  <= ($random(seed) & 3) != 0;
      // Stream holds a word until taken
      if (axis_tvalid && axis_tready) axis_tdata <= axis_tdata + 1'b1;
      if (!axis_tvalid || axis_tready) axis_tvalid <= ($random(seed) & 7) != 0;
      if (awvalid && awready) aw_done++;
      if (wvalid && wready && w.last) wlast_done++;
      // Burst complete on both channels schedules its response
      if (paired < aw_done && paired < wlast_done) begin
        paired++;
        delay = 3 + ($unsigned($random(seed)) % 8);
        if (slow_resp) delay = delay + slow_extra;
        resp_due.push_back(cycle + delay);
      end
      // Responses leave in order, a late one holds back the rest
      if (resp_due.size() != 0 && resp_due[0] <= cycle) begin
        bvalid <= 1'b1;
        void'(resp_due.pop_front());
      end else begin
        bvalid <= 1'b0;
      end
      cycle++;
    end
  end

  //////////////////////////////////////////////////
  // Reset and commands
  //////////////////////////////////////////////////
  initial begin
    areset    = 1'b1;
    start     = 1'b0;
    cmd       = '0;
    slow_resp = 1'b0;
    repeat (4) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    for (int t = 0; t < n_tests; t++) begin
      start          <= 1'b1;
      cmd.addr       <= test_addr[t];
      cmd.size_bytes <= 20'(test_size[t]);
      slow_resp      <= (t == n_tests - 1);
      @(posedge aclk);
      start <= 1'b0;
      @(posedge aclk);
      while (!done) @(posedge aclk);
    end
    // Idle tail catches a stray done or response
    repeat (20) @(posedge aclk);
    $display("tests %0d run, %0d passed, %0d errors", tests_run, tests_passed, error_count);
    if (error_count == 0 && tests_passed == n_tests) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the beats of all commands
  initial begin
    longint unsigned limit;
    limit = 2000;
    for (int t = 0; t < n_tests; t++) begin
      limit = limit + 40 * ((test_size[t] + 3) / 4);
    end
    repeat (limit) @(posedge aclk);
    $display("Timeout after %0d cycles with %0d of %0d commands finished", limit, tests_run,
             n_tests);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/wm_checker.sv
/*
 * Scoreboard for the write master that watches top-level ports only
 * Expects one command at a time and start never while a command runs
 * Stream words count up from word_base across all commands
 */
`default_nettype none

module wm_checker #(
  parameter logic [31:0] word_base = '0
) (
  input  wire logic             aclk,
  input  wire logic             areset,
  input  wire logic             start,
  input  wire wm_cfg_pkg::cmd_t cmd,
  input  wire logic             done,
  input  wire logic             awvalid,
  input  wire logic             awready,
  input  wire wm_axi_pkg::aw_t  aw,
  input  wire logic             wvalid,
  input  wire logic             wready,
  input  wire wm_axi_pkg::w_t   w,
  input  wire logic             bvalid,
  input  wire logic             bready,
  output int unsigned           error_count,
  output int unsigned           tests_run,
  output int unsigned           tests_passed
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected bursts of the running command in issue order
  logic [31:0] exp_addr_q [$];
  logic [7:0]  exp_len_q [$];
  int unsigned burst_beats_q [$];
  logic [3:0]  exp_final_strb;
  int unsigned exp_bursts;
  int unsigned exp_beats;

  string       test_name;
  logic        active;
  logic        done_due;
  logic        first_counted;
  logic [31:0] next_word;
  int unsigned test_errors;
  int unsigned aw_count;
  int unsigned b_count;
  int unsigned beat_count;
  int unsigned beat_in_burst;
  int unsigned first_seen;

  // Reference model
  // Beats are bytes over 4 rounded up and split into 256-beat bursts 1 KiB apart
  function automatic void plan_bursts(input logic [31:0] addr, input int unsigned size);
    int unsigned left;
    int unsigned n_beats;
    int unsigned idx;
    left           = (size + wm_axi_pkg::strb_w - 1) / wm_axi_pkg::strb_w;
    exp_beats      = left;
    exp_final_strb = (size % wm_axi_pkg::strb_w == 0) ? 4'hf
                                                       : 4'((1 << (size % wm_axi_pkg::strb_w)) - 1);
    idx = 0;
    while (left > 0) begin
      n_beats = (left > wm_axi_pkg::max_burst_beats) ? wm_axi_pkg::max_burst_beats : left;
      exp_addr_q.push_back(addr + idx * wm_axi_pkg::burst_bytes);
      exp_len_q.push_back(8'(n_beats - 1));
      burst_beats_q.push_back(n_beats);
      left = left - n_beats;
      idx++;
    end
    exp_bursts = idx;
  endfunction

  task automatic mismatch(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
    error_count++;
    test_errors++;
  endtask

  task automatic protocol_fault(input string what);
    $display("FAIL %s: %s", test_name, what);
    error_count++;
    test_errors++;
  endtask

  // Totals of the command and its one result line
  task automatic close_test();
    if (beat_count != exp_beats) mismatch("beat count", exp_beats, beat_count);
    if (aw_count != exp_bursts) mismatch("AW count", exp_bursts, aw_count);
    if (b_count != exp_bursts) mismatch("B count", exp_bursts, b_count);
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("PASS %s", test_name);
    end else begin
      $display("FAIL %s expected 0 errors actual %0d", test_name, test_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // Port monitor sampled on the rising edge
  //////////////////////////////////////////////////
  always @(posedge aclk) begin : compare
    logic       last_exp;
    logic [3:0] strb_exp;
    if (areset) begin
      error_count  = 0;
      tests_run    = 0;
      tests_passed = 0;
      test_errors  = 0;
      active       = 1'b0;
      done_due     = 1'b0;
      next_word    = word_base;
      test_name    = "reset";
    end else begin
      // Done belongs exactly one cycle after the final response
      if (done_due && !done) protocol_fault("done missing one cycle after the final response");
      if (done) begin
        if (!active) begin
          protocol_fault("done pulse with no command running");
        end else begin
          if (!done_due) protocol_fault("done pulse before the final response");
          close_test();
        end
        active = 1'b0;
      end
      done_due = 1'b0;

      // Quiet bus between commands
      if (!active && awvalid) protocol_fault("awvalid high with no command running");
      if (!active && wvalid) protocol_fault("wvalid high with no command running");

      if (start) begin
        test_errors = 0;
        test_name   = $sformatf("test%0d size %0d", tests_run, cmd.size_bytes);
        exp_addr_q.delete();
        exp_len_q.delete();
        burst_beats_q.delete();
        plan_bursts(cmd.addr, cmd.size_bytes);
        aw_count      = 0;
        b_count       = 0;
        beat_count    = 0;
        beat_in_burst = 0;
        first_seen    = 0;
        first_counted = 1'b0;
        active        = 1'b1;
      end

      if (active) begin
        // AW order and lengths with the first beat already shown
        if (awvalid && awready) begin
          if (exp_addr_q.size() == 0) begin
            protocol_fault("AW transfer beyond the expected bursts");
          end else begin
            if (aw.addr != exp_addr_q[0]) mismatch("AW addr", exp_addr_q[0], aw.addr);
            if (aw.len != exp_len_q[0]) mismatch("AW len", exp_len_q[0], aw.len);
            void'(exp_addr_q.pop_front());
            void'(exp_len_q.pop_front());
          end
          if (aw_count >= first_seen) protocol_fault("AW transfer before its first W beat");
          aw_count++;
        end

        // First beat of a burst presented on W
        if (wvalid && beat_in_burst == 0 && !first_counted) begin
          first_seen++;
          first_counted = 1'b1;
        end

        if (wvalid && wready) begin
          if (burst_beats_q.size() == 0) begin
            protocol_fault("W beat beyond the command length");
          end else begin
            if (w.data != next_word) mismatch("W data", next_word, w.data);
            last_exp = (beat_in_burst + 1 == burst_beats_q[0]);
            if (w.last != last_exp) mismatch("W last", last_exp, w.last);
            // Partial strobe only on the closing beat of the command
            strb_exp = (last_exp && burst_beats_q.size() == 1) ? exp_final_strb : 4'hf;
            if (w.strb != strb_exp) mismatch("W strb", strb_exp, w.strb);
            beat_in_burst++;
            if (last_exp) begin
              beat_in_burst = 0;
              first_counted = 1'b0;
              void'(burst_beats_q.pop_front());
            end
          end
          next_word++;
          beat_count++;
        end

        if (bvalid && bready) begin
          b_count++;
          if (b_count > exp_bursts) begin
            protocol_fault("write response beyond the expected bursts");
          end else if (b_count == exp_bursts) begin
            done_due = 1'b1;
          end
        end

        // Outstanding limit
        if (aw_count > b_count + wm_cfg_pkg::max_outstanding) begin
          protocol_fault($sformatf("%0d bursts await a response", aw_count - b_count));
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sources.f
design/wm_axi_pkg.sv
design/wm_cfg_pkg.sv
design/wm_counter.sv
design/wm_cmd_ctrl.sv
design/wm_data_channel.sv
design/wm_addr_channel.sv
design/wm_resp_tracker.sv
design/wm_top.sv
sim/wm_checker.sv
sim/tb_top.sv
